/* Makefile */
VERILATOR  = verilator
FLAGS      = --binary --timing --assert --timescale 1ns/100ps -j 0
LINT_FLAGS = --lint-only --timing --assert --timescale 1ns/100ps
TOP        = vec_tb
FILELIST   = files.f
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* files.f */
logic/vec_pkg.sv
logic/apb_host_port.sv
logic/inst_decode.sv
logic/operand_mem.sv
logic/lane_alu.sv
logic/vec_top.sv
testbench/tb_clock.sv
testbench/vec_assertions.sv
testbench/vec_tb.sv

/* logic/apb_host_port.sv */
`default_nettype none

module apb_host_port #(
    parameter int RETIRE_COUNT_W = 16
) (
    input  wire logic                            clk,
    input  wire logic                            rst,
    input  wire logic                            psel,
    input  wire logic                            penable,
    input  wire logic                            pwrite,
    input  wire logic [vec_pkg::apb_addr_w-1:0]  paddr,
    input  wire logic [vec_pkg::word_w-1:0]      pwdata,
    output logic      [vec_pkg::word_w-1:0]      prdata,
    output logic                                 pready,
    output logic                                 pslverr,
    output logic                                 inst_valid,
    output vec_pkg::vec_inst_t                   inst,
    input  wire logic                            inst_accept,
    input  wire logic                            inst_illegal,
    output logic                                 mem_req,
    output logic                                 mem_we,
    output logic      [vec_pkg::addr_w-1:0]      mem_addr,
    output logic      [vec_pkg::word_w-1:0]      mem_wdata,
    input  wire logic                            mem_grant,
    input  wire logic [vec_pkg::word_w-1:0]      mem_rdata,
    input  var  vec_pkg::wb_t                    wb
);

    logic                          access;
    logic                          hit_mem;
    logic                          hit_inst;
    logic                          hit_retired;
    logic                          addr_err;
    logic                          rd_wait;
    logic [RETIRE_COUNT_W-1:0]     retired;
    logic [vec_pkg::word_w-1:0]    retired_ext;

    //////////////////////////////////////////////////
    // address decode
    //////////////////////////////////////////////////

    assign access      = psel & penable;
    assign hit_mem     = ~paddr[vec_pkg::mem_window];
    assign hit_inst    = (paddr == vec_pkg::inst_reg_addr);
    assign hit_retired = (paddr == vec_pkg::retired_addr);

    // wrong direction on a register, or nothing mapped there
    assign addr_err = (hit_inst & ~pwrite) | (hit_retired & pwrite)
                    | (~hit_mem & ~hit_inst & ~hit_retired);

    // instruction offer, decode answers in the same cycle
    assign inst_valid = access & hit_inst & pwrite;
    assign inst       = pwdata;

    // memory request, held off while read data is in flight
    assign mem_req   = access & hit_mem & ~rd_wait;
    assign mem_we    = pwrite;
    assign mem_addr  = paddr[vec_pkg::mem_index_lsb +: vec_pkg::addr_w];
    assign mem_wdata = pwdata;

    //////////////////////////////////////////////////
    // completion
    //////////////////////////////////////////////////

    // read grant now, data next cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_wait <= 1'b0;
        end else begin
            rd_wait <= mem_req & ~mem_we & mem_grant;
        end
    end

    // counter, error and instruction answers close on the first access cycle
    assign pready = rd_wait
                  | (mem_req & mem_we & mem_grant)
                  | (access & hit_retired & ~pwrite)
                  | (access & addr_err)
                  | inst_accept
                  | inst_illegal;

    assign pslverr = (access & addr_err) | inst_illegal;

    // zero extend the counter onto the bus
    always_comb begin
        retired_ext = '0;
        retired_ext[RETIRE_COUNT_W-1:0] = retired;
    end

    always_comb begin
        prdata = '0;
        if (rd_wait) begin
            prdata = mem_rdata;
        end else if (access & hit_retired & ~pwrite) begin
            prdata = retired_ext;
        end
    end

    // one retire per write-back, wraps at counter width
    always_ff @(posedge clk) begin
        if (rst) begin
            retired <= '0;
        end else if (wb.valid) begin
            retired <= retired + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* logic/inst_decode.sv */
`default_nettype none

module inst_decode (
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire logic         inst_valid,
    input  var  vec_pkg::vec_inst_t inst,
    input  var  vec_pkg::operand_t  operands,
    input  var  vec_pkg::wb_t       wb,
    output logic              inst_accept,
    output logic              inst_illegal,
    output vec_pkg::issue_t   issue
);

    logic legal;
    logic hazard;

    // true when a valid stage writes the given source
    function automatic logic src_busy(
        input logic [vec_pkg::addr_w-1:0] src,
        input logic                       stage_valid,
        input logic [vec_pkg::addr_w-1:0] stage_rd
    );
        return stage_valid && (src == stage_rd);
    endfunction

    //////////////////////////////////////////////////
    // opcode check
    //////////////////////////////////////////////////

    always_comb begin
        case (vec_pkg::vec_op_e'(inst.op))
            vec_pkg::op_add,
            vec_pkg::op_sub,
            vec_pkg::op_mul,
            vec_pkg::op_and,
            vec_pkg::op_xor: legal = 1'b1;
            default:         legal = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////
    // scoreboard
    //////////////////////////////////////////////////

    // either source pending in issue, operand or write-back
    assign hazard = src_busy(inst.rs0, issue.valid, issue.rd)
                  | src_busy(inst.rs1, issue.valid, issue.rd)
                  | src_busy(inst.rs0, operands.valid, operands.rd)
                  | src_busy(inst.rs1, operands.valid, operands.rd)
                  | src_busy(inst.rs0, wb.valid, wb.rd)
                  | src_busy(inst.rs1, wb.valid, wb.rd);

    // refused at once, hazard or not
    assign inst_illegal = inst_valid & ~legal;
    // stall by leaving accept low
    assign inst_accept  = inst_valid & legal & ~hazard;

    // issue register, bubble when nothing accepted
    always_ff @(posedge clk) begin
        if (rst) begin
            issue.valid <= 1'b0;
        end else begin
            issue.valid <= inst_accept;
        end
        issue.op  <= vec_pkg::vec_op_e'(inst.op);
        issue.rd  <= inst.rd;
        issue.rs0 <= inst.rs0;
        issue.rs1 <= inst.rs1;
    end

endmodule

`default_nettype wire

/* logic/lane_alu.sv */
`default_nettype none

module lane_alu (
    input  wire logic               clk,
    input  wire logic               rst,
    input  var  vec_pkg::operand_t  operands,
    output vec_pkg::wb_t            wb
);

    logic [vec_pkg::word_w-1:0] result;

    // one lane, everything kept to lane width so it wraps
    function automatic logic [vec_pkg::lane_w-1:0] lane_op(
        input vec_pkg::vec_op_e           op,
        input logic [vec_pkg::lane_w-1:0] a,
        input logic [vec_pkg::lane_w-1:0] b
    );
        logic [vec_pkg::lane_w-1:0] r;
        case (op)
            vec_pkg::op_add: r = a + b;
            vec_pkg::op_sub: r = a - b;
            // low half of the product
            vec_pkg::op_mul: r = a * b;
            vec_pkg::op_and: r = a & b;
            vec_pkg::op_xor: r = a ^ b;
            default:         r = '0;
        endcase
        return r;
    endfunction

    //////////////////////////////////////////////////
    // lanes
    //////////////////////////////////////////////////

    // each lane on its own, no carry between them
    always_comb begin
        result = '0;
        for (int l = 0; l < vec_pkg::lane_n; l++) begin
            result[l*vec_pkg::lane_w +: vec_pkg::lane_w] =
                lane_op(operands.op,
                        operands.a[l*vec_pkg::lane_w +: vec_pkg::lane_w],
                        operands.b[l*vec_pkg::lane_w +: vec_pkg::lane_w]);
        end
    end

    // write-back record
    always_ff @(posedge clk) begin
        if (rst) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= operands.valid;
        end
        wb.rd   <= operands.rd;
        wb.data <= result;
    end

endmodule

`default_nettype wire

/* logic/operand_mem.sv */
`default_nettype none

module operand_mem (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  var  vec_pkg::issue_t             issue,
    input  var  vec_pkg::wb_t                wb,
    input  wire logic                        mem_req,
    input  wire logic                        mem_we,
    input  wire logic [vec_pkg::addr_w-1:0]  mem_addr,
    input  wire logic [vec_pkg::word_w-1:0]  mem_wdata,
    output vec_pkg::operand_t                operands,
    output logic                             mem_grant,
    output logic      [vec_pkg::word_w-1:0]  mem_rdata
);

    localparam int depth = 2 ** vec_pkg::addr_w;

    logic [vec_pkg::word_w-1:0] mem [depth];

    logic                       host_wr_grant;
    logic                       host_rd_grant;
    logic [vec_pkg::addr_w-1:0] raddr0;
    logic                       wr_en;
    logic [vec_pkg::addr_w-1:0] wr_addr;
    logic [vec_pkg::word_w-1:0] wr_data;
    logic [vec_pkg::word_w-1:0] rdata0;
    logic [vec_pkg::word_w-1:0] rdata1;
    logic                       op_valid;
    vec_pkg::vec_op_e           op_q;
    logic [vec_pkg::addr_w-1:0] rd_q;

    //////////////////////////////////////////////////
    // host arbitration
    //////////////////////////////////////////////////

    // write loses to write-back
    assign host_wr_grant = mem_req & mem_we & ~wb.valid;
    // read loses to an issued instruction on port 0
    assign host_rd_grant = mem_req & ~mem_we & ~issue.valid;
    assign mem_grant     = host_wr_grant | host_rd_grant;

    //////////////////////////////////////////////////
    // ports
    //////////////////////////////////////////////////

    // port 0 shared, pipeline first
    assign raddr0 = issue.valid ? issue.rs0 : mem_addr;

    // single write port, write-back first
    assign wr_en   = wb.valid | host_wr_grant;
    assign wr_addr = wb.valid ? wb.rd : mem_addr;
    assign wr_data = wb.valid ? wb.data : mem_wdata;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered reads, block ram style
    always_ff @(posedge clk) begin
        rdata0 <= mem[raddr0];
        rdata1 <= mem[issue.rs1];
    end

    // host read data comes off port 0
    assign mem_rdata = rdata0;

    //////////////////////////////////////////////////
    // operand record
    //////////////////////////////////////////////////

    // opcode and rd ride along with the read
    always_ff @(posedge clk) begin
        if (rst) begin
            op_valid <= 1'b0;
        end else begin
            op_valid <= issue.valid;
        end
        op_q <= issue.op;
        rd_q <= issue.rd;
    end

    always_comb begin
        operands.valid = op_valid;
        operands.op    = op_q;
        operands.rd    = rd_q;
        operands.a     = rdata0;
        operands.b     = rdata1;
    end

endmodule

`default_nettype wire

/* logic/vec_pkg.sv */
`default_nettype none

package vec_pkg;

    //////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////

    // one lane and the two-lane memory word
    localparam int lane_w = 16;
    localparam int lane_n = 2;
    localparam int word_w = lane_n * lane_w;

    // 256-word operand memory
    localparam int addr_w = 8;

    // apb byte address
    localparam int apb_addr_w = 12;

    //////////////////////////////////////////////////
    // address map
    //////////////////////////////////////////////////

    // paddr bit that leaves the memory window when set
    localparam int mem_window = 10;
    // word index sits in paddr[9:2]
    localparam int mem_index_lsb = 2;
    localparam logic [apb_addr_w-1:0] inst_reg_addr = 12'h400;
    localparam logic [apb_addr_w-1:0] retired_addr = 12'h404;

    //////////////////////////////////////////////////
    // opcodes and records
    //////////////////////////////////////////////////

    typedef enum logic [3:0] {
        op_add = 4'h0,
        op_sub = 4'h1,
        op_mul = 4'h2,
        op_and = 4'h3,
        op_xor = 4'h4
    } vec_op_e;

    // host instruction word, op kept raw so undefined codes can be seen
    typedef struct packed {
        logic [3:0]        op;
        logic [3:0]        rsvd;
        logic [addr_w-1:0] rd;
        logic [addr_w-1:0] rs1;
        logic [addr_w-1:0] rs0;
    } vec_inst_t;

    // decode to operand read
    typedef struct packed {
        logic              valid;
        vec_op_e           op;
        logic [addr_w-1:0] rd;
        logic [addr_w-1:0] rs0;
        logic [addr_w-1:0] rs1;
    } issue_t;

    // operand read to alu
    typedef struct packed {
        logic              valid;
        vec_op_e           op;
        logic [addr_w-1:0] rd;
        logic [word_w-1:0] a;
        logic [word_w-1:0] b;
    } operand_t;

    // alu back to the memory write port
    typedef struct packed {
        logic              valid;
        logic [addr_w-1:0] rd;
        logic [word_w-1:0] data;
    } wb_t;

endpackage

`default_nettype wire

/* logic/vec_top.sv */
`default_nettype none

module vec_top #(
    parameter int RETIRE_COUNT_W = 16
) (
    input  wire logic                            clk,
    input  wire logic                            rst,
    input  wire logic                            psel,
    input  wire logic                            penable,
    input  wire logic                            pwrite,
    input  wire logic [vec_pkg::apb_addr_w-1:0]  paddr,
    input  wire logic [vec_pkg::word_w-1:0]      pwdata,
    output logic      [vec_pkg::word_w-1:0]      prdata,
    output logic                                 pready,
    output logic                                 pslverr
);

    // host to decode
    logic                        inst_valid;
    vec_pkg::vec_inst_t          inst;
    logic                        inst_accept;
    logic                        inst_illegal;

    // host memory access
    logic                        mem_req;
    logic                        mem_we;
    logic [vec_pkg::addr_w-1:0]  mem_addr;
    logic [vec_pkg::word_w-1:0]  mem_wdata;
    logic                        mem_grant;
    logic [vec_pkg::word_w-1:0]  mem_rdata;

    // pipeline records
    vec_pkg::issue_t             issue;
    vec_pkg::operand_t           operands;
    vec_pkg::wb_t                wb;

    apb_host_port #(
        .RETIRE_COUNT_W (RETIRE_COUNT_W)
    ) u_host (
        .clk          (clk),
        .rst          (rst),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .inst_accept  (inst_accept),
        .inst_illegal (inst_illegal),
        .mem_req      (mem_req),
        .mem_we       (mem_we),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_grant    (mem_grant),
        .mem_rdata    (mem_rdata),
        .wb           (wb)
    );

    // decode and scoreboard
    inst_decode u_decode (
        .clk          (clk),
        .rst          (rst),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .operands     (operands),
        .wb           (wb),
        .inst_accept  (inst_accept),
        .inst_illegal (inst_illegal),
        .issue        (issue)
    );

    // operand read and write-back
    operand_mem u_mem (
        .clk       (clk),
        .rst       (rst),
        .issue     (issue),
        .wb        (wb),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .operands  (operands),
        .mem_grant (mem_grant),
        .mem_rdata (mem_rdata)
    );

    lane_alu u_alu (
        .clk      (clk),
        .rst      (rst),
        .operands (operands),
        .wb       (wb)
    );

endmodule

`default_nettype wire

/* testbench/tb_clock.sv */
`default_nettype none

module tb_clock (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    // 100 ns period
    localparam int half_period = 50;

    initial begin
        clk = 1'b0;
        forever begin
            #half_period;
            clk = ~clk;
        end
    end

endmodule

`default_nettype wire

/* testbench/vec_assertions.sv */
`default_nettype none

module vec_assertions (
    input wire logic          clk,
    input wire logic          rst,
    input wire logic          psel,
    input wire logic          penable,
    input wire logic          pwrite,
    input wire logic [vec_pkg::apb_addr_w-1:0] paddr,
    input wire logic          pready,
    input wire logic          pslverr,
    input wire logic          inst_accept,
    input var  vec_pkg::vec_inst_t inst,
    input var  vec_pkg::wb_t       wb
);
    timeunit 1ns;
    timeprecision 100ps;

    // error response closes the transfer, one cycle only
    slverr_needs_ready: assert property (@(posedge clk) disable iff (rst)
        pslverr |-> pready ##1 !pready)
        else $error("pslverr without pready, or response held past completion");

    // write-back owns the single write port, host memory write waits
    host_write_vs_wb: assert property (@(posedge clk) disable iff (rst)
        (psel && penable && pwrite && !paddr[vec_pkg::mem_window] && wb.valid)
            |-> !pready)
        else $error("host write completed during a write-back");

    // decode, operand read, alu, then the record is on wb
    wb_three_after_accept: assert property (@(posedge clk) disable iff (rst)
        $past(inst_accept, 3) |-> (wb.valid && wb.rd == $past(inst.rd, 3)))
        else $error("write-back missing three cycles after accept");

endmodule

`default_nettype wire

/* testbench/vec_tb.sv */
`default_nettype none

module vec_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int drive_dly = 1;
    // ~200 transfers, worst case ~10 cycles each with stalls, plus reset, doubled
    localparam int max_cycles = 4000;

    logic        clk;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    // shadow of the operand memory, lane model writes here
    logic [31:0] shadow [256];
    logic [15:0] lfsr_state;
    int          errors;
    int          transfers;
    int          retired_exp;
    int          cycles = 0;

    tb_clock u_clock (
        .clk (clk)
    );

    vec_top dut (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    bind vec_top vec_assertions u_checks (
        .clk         (clk),
        .rst         (rst),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pready      (pready),
        .pslverr     (pslverr),
        .inst_accept (inst_accept),
        .inst        (inst),
        .wb          (wb)
    );

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    task automatic report_mismatch(input string msg);
        errors++;
        $display("CHECK FAILED at %0t: %s", $time, msg);
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    // 3-bit code to one of the five ops, upper codes fold back
    function automatic vec_pkg::vec_op_e pick_op(input logic [2:0] code);
        case (code)
            3'd1, 3'd6: return vec_pkg::op_sub;
            3'd2, 3'd7: return vec_pkg::op_mul;
            3'd3:       return vec_pkg::op_and;
            3'd4:       return vec_pkg::op_xor;
            default:    return vec_pkg::op_add;
        endcase
    endfunction

    // lane model, each lane in 32 bits then cut to 16
    function automatic logic [31:0] model_op(
        input vec_pkg::vec_op_e op,
        input logic [31:0]      a,
        input logic [31:0]      b
    );
        logic [31:0] hi;
        logic [31:0] lo;
        logic [31:0] ah;
        logic [31:0] al;
        logic [31:0] bh;
        logic [31:0] bl;
        ah = {16'h0, a[31:16]};
        al = {16'h0, a[15:0]};
        bh = {16'h0, b[31:16]};
        bl = {16'h0, b[15:0]};
        case (op)
            vec_pkg::op_add: begin
                hi = ah + bh;
                lo = al + bl;
            end
            vec_pkg::op_sub: begin
                hi = ah - bh;
                lo = al - bl;
            end
            vec_pkg::op_mul: begin
                hi = ah * bh;
                lo = al * bl;
            end
            vec_pkg::op_and: begin
                hi = ah & bh;
                lo = al & bl;
            end
            default: begin
                hi = ah ^ bh;
                lo = al ^ bl;
            end
        endcase
        return {hi[15:0], lo[15:0]};
    endfunction

    //////////////////////////////////////////////////
    // apb access
    //////////////////////////////////////////////////

    // setup, access, wait for pready mid-cycle, complete at the next edge
    task automatic apb_xfer(
        input  logic        write,
        input  logic [11:0] addr,
        input  logic [31:0] wdata,
        output logic [31:0] rdata,
        output logic        err
    );
        @(posedge clk);
        #drive_dly;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #drive_dly;
        penable = 1'b1;
        @(negedge clk);
        while (!pready) begin
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #drive_dly;
        psel    = 1'b0;
        penable = 1'b0;
        transfers++;
    endtask

    task automatic mem_write(input logic [7:0] idx, input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        apb_xfer(1'b1, {2'b00, idx, 2'b00}, data, rdata, err);
        if (err) begin
            report_mismatch($sformatf("slave error writing word %0d", idx));
        end
        shadow[idx] = data;
    endtask

    // read a word and compare with the shadow
    task automatic check_word(input logic [7:0] idx);
        logic [31:0] rdata;
        logic        err;
        apb_xfer(1'b0, {2'b00, idx, 2'b00}, '0, rdata, err);
        if (err || rdata !== shadow[idx]) begin
            report_mismatch($sformatf("word %0d read %08h err %0b, expected %08h",
                                      idx, rdata, err, shadow[idx]));
        end
    endtask

    task automatic send_inst(
        input  logic [3:0] op,
        input  logic [7:0] rd,
        input  logic [7:0] rs0,
        input  logic [7:0] rs1,
        output logic       err
    );
        vec_pkg::vec_inst_t word;
        logic [31:0]        rdata;
        word.op   = op;
        word.rsvd = 4'h0;
        word.rd   = rd;
        word.rs1  = rs1;
        word.rs0  = rs0;
        apb_xfer(1'b1, vec_pkg::inst_reg_addr, word, rdata, err);
    endtask

    task automatic issue_legal(
        input vec_pkg::vec_op_e op,
        input logic [7:0]       rd,
        input logic [7:0]       rs0,
        input logic [7:0]       rs1
    );
        logic err;
        send_inst(op, rd, rs0, rs1, err);
        if (err) begin
            report_mismatch($sformatf("slave error on legal op %0d to word %0d", op, rd));
        end
        shadow[rd] = model_op(op, shadow[rs0], shadow[rs1]);
        retired_exp++;
    endtask

    task automatic read_retired(output logic [31:0] count);
        logic err;
        apb_xfer(1'b0, vec_pkg::retired_addr, '0, count, err);
        if (err) begin
            report_mismatch("slave error reading retired count");
        end
    endtask

    // poll until the pipeline drains, a dozen polls at most
    task automatic wait_retired(input string what);
        logic [31:0] count;
        logic [31:0] exp;
        int          polls;
        exp   = {16'h0, 16'(retired_exp)};
        polls = 0;
        read_retired(count);
        while (count !== exp && polls < 12) begin
            read_retired(count);
            polls++;
        end
        if (count !== exp) begin
            report_mismatch($sformatf("%s retired %0d, expected %0d", what, count, exp));
        end
    endtask

    //////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////

    task automatic test_mem_rw();
        for (int i = 0; i < 8; i++) begin
            mem_write(8'(i * 29 + 3), rand_bits(32));
        end
        for (int i = 0; i < 8; i++) begin
            check_word(8'(i * 29 + 3));
        end
    endtask

    // every op over carry and borrow corners plus random words
    task automatic test_ops();
        logic [7:0] src0 [4] = '{8'd0, 8'd1, 8'd2, 8'd4};
        logic [7:0] src1 [4] = '{8'd1, 8'd0, 8'd3, 8'd5};
        logic [7:0] rd;
        mem_write(8'd0, 32'hFFFF_FFFF);
        mem_write(8'd1, 32'h0001_0001);
        mem_write(8'd2, 32'h8000_FFFF);
        mem_write(8'd3, 32'h0002_7FFF);
        for (int w = 4; w < 8; w++) begin
            mem_write(8'(w), rand_bits(32));
        end
        for (int p = 0; p < 4; p++) begin
            for (int k = 0; k < 5; k++) begin
                rd = {3'b001, p[1:0], k[2:0]};
                issue_legal(pick_op(k[2:0]), rd, src0[p], src1[p]);
            end
        end
        wait_retired("ops");
        for (int p = 0; p < 4; p++) begin
            for (int k = 0; k < 5; k++) begin
                check_word({3'b001, p[1:0], k[2:0]});
            end
        end
    endtask

    // each one reads the previous result, back to back
    task automatic test_chain();
        mem_write(8'd10, rand_bits(32));
        mem_write(8'd11, rand_bits(32));
        mem_write(8'd12, rand_bits(32));
        issue_legal(vec_pkg::op_add, 8'd20, 8'd10, 8'd11);
        issue_legal(vec_pkg::op_mul, 8'd21, 8'd20, 8'd12);
        issue_legal(vec_pkg::op_xor, 8'd22, 8'd21, 8'd20);
        issue_legal(vec_pkg::op_sub, 8'd23, 8'd22, 8'd10);
        issue_legal(vec_pkg::op_and, 8'd24, 8'd23, 8'd21);
        issue_legal(vec_pkg::op_add, 8'd20, 8'd24, 8'd22);
        // lands on the last write-back, host write has to wait a cycle
        mem_write(8'd25, rand_bits(32));
        wait_retired("chain");
        for (int w = 20; w < 26; w++) begin
            check_word(8'(w));
        end
    endtask

    task automatic test_errors();
        logic [31:0] rdata;
        logic        err;
        send_inst(4'hF, 8'd10, 8'd11, 8'd12, err);
        if (!err) begin
            report_mismatch("undefined opcode accepted without pslverr");
        end
        apb_xfer(1'b1, vec_pkg::retired_addr, 32'h1234_5678, rdata, err);
        if (!err) begin
            report_mismatch("write to retired count without pslverr");
        end
        apb_xfer(1'b0, vec_pkg::inst_reg_addr, '0, rdata, err);
        if (!err) begin
            report_mismatch("read of instruction register without pslverr");
        end
        apb_xfer(1'b0, 12'h40C, '0, rdata, err);
        if (!err) begin
            report_mismatch("read of unmapped address without pslverr");
        end
        wait_retired("after errors");
        check_word(8'd10);
    endtask

    task automatic test_retire_count();
        logic [31:0] start;
        logic [31:0] done;
        logic [31:0] r;
        read_retired(start);
        for (int i = 0; i < 6; i++) begin
            r = rand_bits(12);
            issue_legal(pick_op(r[11:9]), {5'b00001, r[8:6]}, {5'b0, r[5:3]}, {5'b0, r[2:0]});
        end
        wait_retired("batch");
        read_retired(done);
        if (done - start != 32'd6) begin
            report_mismatch($sformatf("batch of 6 moved count by %0d", done - start));
        end
    endtask

    // 40 random instructions over words 64 to 79
    task automatic test_random();
        logic [31:0] r;
        for (int w = 64; w < 80; w++) begin
            mem_write(8'(w), rand_bits(32));
        end
        for (int i = 0; i < 40; i++) begin
            r = rand_bits(15);
            issue_legal(pick_op(r[14:12]), {4'h4, r[11:8]}, {4'h4, r[7:4]}, {4'h4, r[3:0]});
        end
        wait_retired("random");
        for (int w = 64; w < 80; w++) begin
            check_word(8'(w));
        end
    endtask

    //////////////////////////////////////////////////
    // run
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout: run still going after %0d cycles", max_cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        rst         = 1'b1;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        errors      = 0;
        transfers   = 0;
        retired_exp = 0;
        lfsr_state  = 16'd31;
        repeat (16) @(posedge clk);
        #drive_dly;
        rst = 1'b0;
        test_mem_rw();
        test_ops();
        test_chain();
        test_errors();
        test_retire_count();
        test_random();
        $display("summary: %0d errors, %0d apb transfers, %0d instructions",
                 errors, transfers, retired_exp);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
